//--- common/fp_pkg.sv
/*
  Shared field widths and types for the binary32 adder.
  The format is fixed at single precision. The widths are not a knob.
  Rounding-mode codes 5 to 7 are not defined and behave as toward zero.
*/
package fp_pkg;

  // --------------------
  // Field widths
  localparam int unsigned word_w = 32;
  localparam int unsigned exp_w  = 8;
  localparam int unsigned frac_w = 23;
  // Fraction plus hidden bit
  localparam int unsigned mant_w = frac_w + 1;
  // Guard, round and sticky
  localparam int unsigned grs_w  = 3;

  // --------------------
  // Vector types
  typedef logic [word_w-1:0]       fp_word_t;
  typedef logic [exp_w-1:0]        fp_exp_t;
  typedef logic [mant_w-1:0]       fp_mant_t;
  // Sum keeps one carry bit above the hidden bit
  typedef logic [mant_w:0]         fp_sum_t;
  // Normalized mantissa with guard, round, sticky at the bottom
  typedef logic [mant_w+grs_w-1:0] fp_ext_t;

  // --------------------
  // Rounding modes, same codes as the r_mode input
  typedef enum logic [2:0] {
    rm_rne = 3'd0,
    rm_rtz = 3'd1,
    rm_rdn = 3'd2,
    rm_rup = 3'd3,
    rm_rmm = 3'd4
  } fp_rmode_e;

  // --------------------
  // Constants
  // Canonical quiet NaN for every invalid or NaN case
  localparam fp_word_t fp_qnan    = 32'h7FC0_0000;
  localparam fp_exp_t  fp_exp_max = 8'hFF;

endpackage

//--- common/fp_align_if.sv
/*
  Align stage to add stage. Mantissas are already aligned to exp_common.
  When special is set the arithmetic fields are don't-care.
*/
interface fp_align_if;

  logic              valid;
  logic              sign_a;
  logic              sign_b;
  fp_pkg::fp_mant_t  mant_a;
  fp_pkg::fp_mant_t  mant_b;
  fp_pkg::fp_exp_t   exp_common;
  fp_pkg::fp_rmode_e rmode;
  logic              special;
  fp_pkg::fp_word_t  special_word;

  modport src (
    output valid, sign_a, sign_b, mant_a, mant_b, exp_common, rmode, special, special_word
  );

  modport dst (
    input  valid, sign_a, sign_b, mant_a, mant_b, exp_common, rmode, special, special_word
  );

endinterface

//--- common/fp_norm_if.sv
/*
  Add stage to round stage. Normalized, still unrounded sum.
  mant_ext holds hidden bit and fraction over guard, round, sticky.
*/
interface fp_norm_if;

  logic              valid;
  logic              sign;
  fp_pkg::fp_exp_t   exp;
  fp_pkg::fp_ext_t   mant_ext;
  fp_pkg::fp_rmode_e rmode;
  logic              special;
  fp_pkg::fp_word_t  special_word;

  modport src (output valid, sign, exp, mant_ext, rmode, special, special_word);

  modport dst (input  valid, sign, exp, mant_ext, rmode, special, special_word);

endinterface

//--- hw/fp_adder/fp_align_stage.sv
/*
  Stage 1: unpack, classify NaN/infinity and align to the larger exponent.
  Bits shifted out of the smaller mantissa are dropped, so they do not
  take part in rounding later. Subnormals align at exponent 1.
*/
module fp_align_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  fp_pkg::fp_word_t  fp_a,
  input  fp_pkg::fp_word_t  fp_b,
  input  fp_pkg::fp_rmode_e r_mode,
  fp_align_if.src           aln
);

  fp_pkg::fp_exp_t  exp_a;
  fp_pkg::fp_exp_t  exp_b;
  fp_pkg::fp_mant_t mant_a;
  fp_pkg::fp_mant_t mant_b;
  logic             nan_a;
  logic             nan_b;
  logic             inf_a;
  logic             inf_b;
  logic             a_larger;
  fp_pkg::fp_exp_t  exp_diff;
  fp_pkg::fp_mant_t mant_small;
  fp_pkg::fp_mant_t mant_shifted;
  fp_pkg::fp_word_t special_word;

  // --------------------
  // Unpack
  // Subnormal: no hidden bit, effective exponent 1
  assign exp_a  = (fp_a[30:23] == '0) ? 8'd1 : fp_a[30:23];
  assign exp_b  = (fp_b[30:23] == '0) ? 8'd1 : fp_b[30:23];
  assign mant_a = {|fp_a[30:23], fp_a[22:0]};
  assign mant_b = {|fp_b[30:23], fp_b[22:0]};

  assign nan_a = (fp_a[30:23] == fp_pkg::fp_exp_max) && (fp_a[22:0] != '0);
  assign nan_b = (fp_b[30:23] == fp_pkg::fp_exp_max) && (fp_b[22:0] != '0);
  assign inf_a = (fp_a[30:23] == fp_pkg::fp_exp_max) && (fp_a[22:0] == '0);
  assign inf_b = (fp_b[30:23] == fp_pkg::fp_exp_max) && (fp_b[22:0] == '0);

  // --------------------
  // Align
  assign a_larger   = (exp_a >= exp_b);
  assign exp_diff   = a_larger ? (exp_a - exp_b) : (exp_b - exp_a);
  assign mant_small = a_larger ? mant_b : mant_a;
  // Anything past 24 places is gone entirely
  assign mant_shifted = (exp_diff > 8'd24) ? '0 : (mant_small >> exp_diff);

  // Result for NaN and infinity operands, bypasses the datapath
  always_comb
  begin
    special_word = fp_pkg::fp_qnan;
    if (!nan_a && !nan_b)
    begin
      if (inf_a && inf_b && (fp_a[31] != fp_b[31]))
        special_word = fp_pkg::fp_qnan;
      else if (inf_a)
        special_word = {fp_a[31], fp_pkg::fp_exp_max, 23'd0};
      else
        special_word = {fp_b[31], fp_pkg::fp_exp_max, 23'd0};
    end
  end

  // --------------------
  // Stage register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      aln.valid <= 1'b0;
    else
      aln.valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    aln.sign_a       <= fp_a[31];
    aln.sign_b       <= fp_b[31];
    aln.mant_a       <= a_larger ? mant_a : mant_shifted;
    aln.mant_b       <= a_larger ? mant_shifted : mant_b;
    aln.exp_common   <= a_larger ? exp_a : exp_b;
    aln.rmode        <= r_mode;
    aln.special      <= nan_a | nan_b | inf_a | inf_b;
    aln.special_word <= special_word;
  end

endmodule

//--- hw/fp_adder/fp_addnorm_stage.sv
/*
  Stage 2: signed mantissa add or subtract, then normalize.
  Any exact zero comes out as +0, including -0 + -0.
  Left shifts stop once the exponent reaches the subnormal value 0.
*/
module fp_addnorm_stage (
  input  logic    clk,
  input  logic    arst_n,
  fp_align_if.dst aln,
  fp_norm_if.src  nrm
);

  fp_pkg::fp_sum_t  sum;
  logic             sum_sign;
  logic             sum_zero;
  logic [4:0]       lz;
  fp_pkg::fp_exp_t  lz_ext;
  logic             to_subnorm;
  fp_pkg::fp_exp_t  shift_amt;
  fp_pkg::fp_mant_t mant_left;
  fp_pkg::fp_exp_t  exp_norm;
  fp_pkg::fp_ext_t  mant_norm;

  // Zeros above the first set bit, 24 for an all-zero input
  function automatic logic [4:0] lead_zeros(input fp_pkg::fp_mant_t value);
    logic [4:0] count;
    logic       found;
    count = 5'd0;
    found = 1'b0;
    for (int i = fp_pkg::mant_w - 1; i >= 0; i--)
    begin
      if (value[i])
        found = 1'b1;
      else if (!found)
        count = count + 5'd1;
    end
    return count;
  endfunction

  // --------------------
  // Add or subtract
  always_comb
  begin
    if (aln.sign_a == aln.sign_b)
    begin
      sum      = {1'b0, aln.mant_a} + {1'b0, aln.mant_b};
      sum_sign = aln.sign_a;
    end
    else if (aln.mant_a >= aln.mant_b)
    begin
      sum      = {1'b0, aln.mant_a} - {1'b0, aln.mant_b};
      sum_sign = aln.sign_a;
    end
    else
    begin
      sum      = {1'b0, aln.mant_b} - {1'b0, aln.mant_a};
      sum_sign = aln.sign_b;
    end
  end

  assign sum_zero = (sum == '0);

  // --------------------
  // Normalize
  assign lz     = lead_zeros(sum[23:0]);
  assign lz_ext = fp_pkg::fp_exp_t'(lz);
  // exp_common is at least 1, so exp_common - 1 never wraps
  assign to_subnorm = (lz_ext >= aln.exp_common);
  assign shift_amt  = to_subnorm ? (aln.exp_common - 8'd1) : lz_ext;
  assign mant_left  = sum[23:0] << shift_amt;

  always_comb
  begin
    if (sum[24])
    begin
      // Carry out: one place right, dropped bit lands in guard
      exp_norm  = aln.exp_common + 8'd1;
      mant_norm = {sum, 2'b00};
    end
    else
    begin
      exp_norm  = (to_subnorm || sum_zero) ? 8'd0 : (aln.exp_common - shift_amt);
      mant_norm = {mant_left, 3'b000};
    end
  end

  // --------------------
  // Stage register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      nrm.valid <= 1'b0;
    else
      nrm.valid <= aln.valid;
  end

  always_ff @(posedge clk)
  begin
    nrm.sign         <= sum_zero ? 1'b0 : sum_sign;
    nrm.exp          <= exp_norm;
    nrm.mant_ext     <= mant_norm;
    nrm.rmode        <= aln.rmode;
    nrm.special      <= aln.special;
    nrm.special_word <= aln.special_word;
  end

endmodule

//--- hw/fp_adder/fp_round_stage.sv
/*
  Stage 3: round by mode, fix up the exponent, pack and raise flags.
  Overflow always gives a signed infinity, whatever the mode.
  Special results (NaN, infinity) carry no flags.
*/
module fp_round_stage (
  input  logic             clk,
  input  logic             arst_n,
  fp_norm_if.dst           nrm,
  output logic             out_valid,
  output fp_pkg::fp_word_t fp_result,
  output logic             overflow,
  output logic             underflow
);

  logic             lsb;
  logic             guard;
  logic             round_bit;
  logic             sticky;
  logic             inexact;
  logic             round_up;
  fp_pkg::fp_sum_t  mant_rnd;
  logic [8:0]       exp_rnd;
  logic [22:0]      frac;
  fp_pkg::fp_word_t result;
  logic             ovf;
  logic             unf;

  assign lsb       = nrm.mant_ext[3];
  assign guard     = nrm.mant_ext[2];
  assign round_bit = nrm.mant_ext[1];
  assign sticky    = nrm.mant_ext[0];
  assign inexact   = guard | round_bit | sticky;

  // --------------------
  // Rounding decision
  always_comb
  begin
    case (nrm.rmode)
      fp_pkg::rm_rne: round_up = guard & (round_bit | sticky | lsb);
      fp_pkg::rm_rtz: round_up = 1'b0;
      // Directed modes grow the magnitude only on the matching sign
      fp_pkg::rm_rdn: round_up = inexact & nrm.sign;
      fp_pkg::rm_rup: round_up = inexact & ~nrm.sign;
      fp_pkg::rm_rmm: round_up = guard;
      default:        round_up = 1'b0;
    endcase
  end

  assign mant_rnd = {1'b0, nrm.mant_ext[26:3]} + fp_pkg::fp_sum_t'(round_up);

  // Rounding carry and subnormal promotion
  always_comb
  begin
    exp_rnd = {1'b0, nrm.exp};
    frac    = mant_rnd[22:0];
    if (mant_rnd[24])
    begin
      exp_rnd = exp_rnd + 9'd1;
      frac    = mant_rnd[23:1];
    end
    else if ((nrm.exp == '0) && mant_rnd[23])
      exp_rnd = 9'd1;
  end

  // --------------------
  // Pack
  always_comb
  begin
    ovf = 1'b0;
    unf = 1'b0;
    if (nrm.special)
      result = nrm.special_word;
    else if (exp_rnd >= {1'b0, fp_pkg::fp_exp_max})
    begin
      result = {nrm.sign, fp_pkg::fp_exp_max, 23'd0};
      ovf    = 1'b1;
    end
    else
    begin
      result = {nrm.sign, exp_rnd[7:0], frac};
      // Tiny and nonzero
      unf    = (exp_rnd == '0) && (frac != '0);
    end
  end

  // --------------------
  // Output register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid <= 1'b0;
      fp_result <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end
    else
    begin
      out_valid <= nrm.valid;
      fp_result <= result;
      overflow  <= ovf;
      underflow <= unf;
    end
  end

endmodule

//--- hw/fp_adder/fp_adder_top.sv
/*
  Three-stage binary32 adder, one operand pair per cycle, no back-pressure.
  Result and flags come with out_valid three clocks after in_valid.
  Flags are limited to overflow and underflow.
*/
module fp_adder_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  fp_pkg::fp_word_t  fp_a,
  input  fp_pkg::fp_word_t  fp_b,
  input  fp_pkg::fp_rmode_e r_mode,
  output logic              out_valid,
  output fp_pkg::fp_word_t  fp_result,
  output logic              overflow,
  output logic              underflow
);

  // Stage-to-stage links
  fp_align_if aln_if ();
  fp_norm_if  nrm_if ();

  // --------------------
  // Unpack and align
  fp_align_stage align0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .fp_a     (fp_a),
    .fp_b     (fp_b),
    .r_mode   (r_mode),
    .aln      (aln_if.src)
  );

  // Add and normalize
  fp_addnorm_stage addnorm0 (
    .clk    (clk),
    .arst_n (arst_n),
    .aln    (aln_if.dst),
    .nrm    (nrm_if.src)
  );

  // Round and pack
  fp_round_stage round0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .nrm       (nrm_if.dst),
    .out_valid (out_valid),
    .fp_result (fp_result),
    .overflow  (overflow),
    .underflow (underflow)
  );

endmodule

//--- bench/fp_adder_scoreboard.sv
/*
  Watches the adder ports and compares each result with the queued
  expectation, in issue order. Also checks the 3-cycle latency.
  Everything is sampled at the rising clock edge.
*/
module fp_adder_scoreboard (
  input logic             clk,
  input logic             arst_n,
  input logic             in_valid,
  input logic             out_valid,
  input fp_pkg::fp_word_t fp_result,
  input logic             overflow,
  input logic             underflow
);

  typedef struct packed {
    logic [31:0]      num;
    fp_pkg::fp_word_t res;
    logic             ovf;
    logic             unf;
  } expect_t;

  expect_t exp_q[$];
  int      issue_q[$];
  int      cycle      = 0;
  int      pass_count = 0;
  int      fail_count = 0;

  task automatic push_expected(input int num, input fp_pkg::fp_word_t res,
                               input logic ovf, input logic unf);
    expect_t entry;
    entry.num = num;
    entry.res = res;
    entry.ovf = ovf;
    entry.unf = unf;
    exp_q.push_back(entry);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  // --------------------
  // Compare at out_valid
  always @(posedge clk)
  begin : compare
    expect_t e;
    int      latency;
    logic    ok;
    if (arst_n)
    begin
      cycle = cycle + 1;
      if (in_valid)
        issue_q.push_back(cycle);
      if (out_valid && (exp_q.size() == 0 || issue_q.size() == 0))
      begin
        $display("Got a result on out_valid while no test was waiting for one");
        fail_count++;
      end
      else if (out_valid)
      begin
        e       = exp_q.pop_front();
        latency = cycle - issue_q.pop_front();
        ok      = 1'b1;
        if (fp_result !== e.res)
        begin
          $display("ERROR test %0d fp_result: got %h, expected %h", e.num, fp_result, e.res);
          ok = 1'b0;
        end
        if (overflow !== e.ovf)
        begin
          $display("ERROR test %0d overflow: got %h, expected %h", e.num, overflow, e.ovf);
          ok = 1'b0;
        end
        if (underflow !== e.unf)
        begin
          $display("ERROR test %0d underflow: got %h, expected %h", e.num, underflow, e.unf);
          ok = 1'b0;
        end
        if (latency != 3)
        begin
          $display("Test %0d came out %0d cycles after its input instead of 3", e.num, latency);
          ok = 1'b0;
        end
        if (ok)
          pass_count++;
        else
          fail_count++;
        $display("test %0d %s", e.num, ok ? "passed" : "failed");
      end
    end
  end

endmodule

//--- bench/fp_adder_chk.sv
/*
  Port-level checks on the adder, bound into fp_adder_top.
  Latency is fixed at 3 cycles and there is no back-pressure.
*/
module fp_adder_chk (
  input logic             clk,
  input logic             arst_n,
  input logic             in_valid,
  input logic             out_valid,
  input fp_pkg::fp_word_t fp_result,
  input logic             overflow,
  input logic             underflow
);

  int err_count = 0;

  // Every input shows up three edges later, and nothing else does
  latency_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid, 3))
    else
    begin
      err_count++;
      $error("out_valid does not match in_valid from 3 cycles before");
    end

  reset_a: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else
    begin
      err_count++;
      $error("out_valid high during reset");
    end

  // Overflow always saturates to a signed infinity
  overflow_a: assert property (@(posedge clk) disable iff (!arst_n)
    overflow |-> (fp_result[30:0] == 31'h7F80_0000))
    else
    begin
      err_count++;
      $error("overflow set but fp_result %h is not infinite", fp_result);
    end

  underflow_a: assert property (@(posedge clk) disable iff (!arst_n)
    underflow |-> (fp_result[30:23] == 8'h00))
    else
    begin
      err_count++;
      $error("underflow set but fp_result %h has a nonzero exponent", fp_result);
    end

endmodule

bind fp_adder_top fp_adder_chk chk0 (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .fp_result (fp_result),
  .overflow  (overflow),
  .underflow (underflow)
);

//--- bench/fp_adder_tb.sv
/*
  Testbench for the binary32 adder. Run from the project root so that
  bench/fp_adder_tests.txt is found. Idle gaps of 0 to 2 cycles between
  tests are random with a fixed seed.
*/
module fp_adder_tb;

  logic              clk;
  logic              arst_n;
  logic              in_valid;
  fp_pkg::fp_word_t  fp_a;
  fp_pkg::fp_word_t  fp_b;
  fp_pkg::fp_rmode_e r_mode;
  logic              out_valid;
  fp_pkg::fp_word_t  fp_result;
  logic              overflow;
  logic              underflow;

  fp_adder_top dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .fp_a      (fp_a),
    .fp_b      (fp_b),
    .r_mode    (r_mode),
    .out_valid (out_valid),
    .fp_result (fp_result),
    .overflow  (overflow),
    .underflow (underflow)
  );

  fp_adder_scoreboard scb0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .fp_result (fp_result),
    .overflow  (overflow),
    .underflow (underflow)
  );

  always #10 clk = ~clk;

  initial
  begin
    int               fd;
    int               num;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      mode;
    logic [31:0]      res;
    logic [31:0]      ovf;
    logic [31:0]      unf;
    logic [8*160-1:0] line;
    int               fields;
    logic             done;
    int               count;
    int               gap;
    int               waited;
    int               seed;
    int               problems;

    clk      = 1'b0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    fp_a     = '0;
    fp_b     = '0;
    r_mode   = fp_pkg::rm_rne;
    seed     = $urandom(32'h3f8a);
    count    = 0;
    problems = 0;

    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // --------------------
    // Stimulus from the data file
    fd = $fopen("bench/fp_adder_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open bench/fp_adder_tests.txt");
      problems++;
    end
    else
    begin
      done = 1'b0;
      while (!done && !$feof(fd))
      begin
        fields = $fscanf(fd, "%d %h %h %h %h %h %h", num, a, b, mode, res, ovf, unf);
        if (fields == 7)
        begin
          fp_a     = a;
          fp_b     = b;
          r_mode   = fp_pkg::fp_rmode_e'(mode[2:0]);
          in_valid = 1'b1;
          scb0.push_expected(num, res, ovf[0], unf[0]);
          count++;
          @(posedge clk);
          #2;
          in_valid = 1'b0;
          gap      = $urandom_range(2, 0);
          repeat (gap)
          begin
            @(posedge clk);
            #2;
          end
        end
        else if (fields == 0)
        begin
          // Comment line, the rest of it is dropped
          if ($fgets(line, fd) == 0)
            done = 1'b1;
        end
        else if (fields < 0)
          done = 1'b1;
        else
        begin
          $display("A line in bench/fp_adder_tests.txt has only %0d of its 7 fields", fields);
          problems++;
          done = 1'b1;
        end
      end
      $fclose(fd);
    end

    // --------------------
    // Drain the pipeline
    waited = 0;
    while (scb0.pending() != 0 && waited < 50)
    begin
      @(posedge clk);
      waited++;
    end
    if (scb0.pending() != 0)
    begin
      $display("Timed out after 50 cycles with %0d results still missing", scb0.pending());
      problems++;
    end
    // A few more edges to catch stray outputs
    repeat (5) @(posedge clk);

    problems = problems + scb0.fail_count + dut0.chk0.err_count;
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             count, scb0.pass_count, scb0.fail_count, dut0.chk0.err_count);
    if (problems == 0 && count > 0 && scb0.pass_count == count)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- bench/fp_adder_tests.txt
// Columns: test, fp_a, fp_b, r_mode, expected fp_result, overflow, underflow
// Test number in decimal, the rest in hex. r_mode 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm
1  00000000 00000000 0 00000000 0 0
2  3F800000 40000000 0 40400000 0 0
3  000A0000 000A0000 1 00140000 0 1
4  3F800000 3D000000 0 3F840000 0 0
5  3F800000 34000000 0 3F800001 0 0
6  3F800000 33000000 0 3F800000 0 0
7  40490FDB C0490FDB 2 00000000 0 0
8  01000000 00300000 1 01180000 0 0
9  3F800001 3F800000 0 40000000 0 0
10 3F800001 3F800000 1 40000000 0 0
11 3F800001 3F800000 2 40000000 0 0
12 3F800001 3F800000 3 40000001 0 0
13 3F800001 3F800000 4 40000001 0 0
14 BF800001 BF800000 2 C0000001 0 0
15 BF800001 BF800000 3 C0000000 0 0
16 3F800003 3F800000 0 40000002 0 0
17 00800001 80800000 0 00000001 0 1
18 3F800001 BF800000 0 34000000 0 0
19 7F7FFFFF 7F7FFFFF 0 7F800000 1 0
20 7F800000 3F800000 0 7F800000 0 0
21 7F800000 FF800000 0 7FC00000 0 0
22 7FC00000 3F800000 0 7FC00000 0 0

//--- list.f
common/fp_pkg.sv
common/fp_align_if.sv
common/fp_norm_if.sv
hw/fp_adder/fp_align_stage.sv
hw/fp_adder/fp_addnorm_stage.sv
hw/fp_adder/fp_round_stage.sv
hw/fp_adder/fp_adder_top.sv
bench/fp_adder_scoreboard.sv
bench/fp_adder_chk.sv
bench/fp_adder_tb.sv

//--- Bender.yml
package:
  name: fp_adder

sources:
  - common/fp_pkg.sv
  - common/fp_align_if.sv
  - common/fp_norm_if.sv
  - hw/fp_adder/fp_align_stage.sv
  - hw/fp_adder/fp_addnorm_stage.sv
  - hw/fp_adder/fp_round_stage.sv
  - hw/fp_adder/fp_adder_top.sv
  - target: test
    files:
      - bench/fp_adder_scoreboard.sv
      - bench/fp_adder_chk.sv
      - bench/fp_adder_tb.sv
